/* common/alu_pkg.sv */
package alu_pkg;

  // width of the operator field shared by decoder, ALU and execute control
  localparam int ALU_OP_WIDTH = 6;

  //////////////////////////////////////////////////////////////////////
  // arithmetic and logic operators
  //////////////////////////////////////////////////////////////////////

  localparam logic [ALU_OP_WIDTH-1:0] ALU_ADD   = 6'b011000;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_SUB   = 6'b011001;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_XOR   = 6'b101111;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_OR    = 6'b101110;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_AND   = 6'b010101;

  // shifts, amount from operand b[4:0]
  localparam logic [ALU_OP_WIDTH-1:0] ALU_SRA   = 6'b100100;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_SRL   = 6'b100101;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_SLL   = 6'b100111;

  //////////////////////////////////////////////////////////////////////
  // comparisons, all return 1 or 0
  //////////////////////////////////////////////////////////////////////

  localparam logic [ALU_OP_WIDTH-1:0] ALU_LTS   = 6'b000000;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_LTU   = 6'b000001;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_LES   = 6'b000100;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_LEU   = 6'b000101;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_GTS   = 6'b001000;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_GTU   = 6'b001001;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_GES   = 6'b001010;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_GEU   = 6'b001011;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_EQ    = 6'b001100;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_NE    = 6'b001101;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_SLTS  = 6'b000010;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_SLTU  = 6'b000011;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_SLETS = 6'b000110;
  localparam logic [ALU_OP_WIDTH-1:0] ALU_SLETU = 6'b000111;

endpackage

/* common/ex_pkg.sv */
package ex_pkg;

  // execute-stage operator for the low word of a * b
  // sits in a code point that the ALU does not decode
  localparam logic [5:0] EX_OP_MUL = 6'b111000;

  //////////////////////////////////////////////////////////////////////
  // multiplier sizing
  //////////////////////////////////////////////////////////////////////

  // one shift-add step per multiplier bit
  localparam int MULT_STEPS = 32;

  // step counter width
  localparam int MULT_CNT_W = $clog2(MULT_STEPS);

endpackage

/* alu/zeroriscy_alu.sv */
`timescale 1ns/1ns

module zeroriscy_alu
  import alu_pkg::*;
(
  input  logic [ALU_OP_WIDTH-1:0] operator_i,
  input  logic [31:0]             operand_a_i,
  input  logic [31:0]             operand_b_i,

  // operands from the multiplier, value in bits 32:1
  input  logic [32:0]             mult_operand_a_i,
  input  logic [32:0]             mult_operand_b_i,
  input  logic                    mult_en_i,

  output logic [31:0]             adder_result_o,
  output logic [31:0]             result_o
);

  //////////////////////////////////////////////////////////////////////
  // shared adder
  //////////////////////////////////////////////////////////////////////

  logic        negate_b;
  logic [32:0] adder_in_a;
  logic [32:0] adder_in_b;
  logic [32:0] adder_sum;
  logic [31:0] adder_result;

  // subtract and every compare run as a - b
  always_comb
  begin
    negate_b = 1'b0;
    unique case (operator_i)
      ALU_SUB,
      ALU_EQ,    ALU_NE,
      ALU_LTS,   ALU_LTU,
      ALU_LES,   ALU_LEU,
      ALU_GTS,   ALU_GTU,
      ALU_GES,   ALU_GEU,
      ALU_SLTS,  ALU_SLTU,
      ALU_SLETS, ALU_SLETU: negate_b = 1'b1;
      default: ;
    endcase
  end

  // low bit of a is 1 so that inverting b's low 0 gives the +1 of
  // two's complement as a carry into bit 1
  assign adder_in_a = mult_en_i ? mult_operand_a_i : {operand_a_i, 1'b1};
  assign adder_in_b = mult_en_i ? mult_operand_b_i
                                : ({operand_b_i, 1'b0} ^ {33{negate_b}});

  assign adder_sum      = adder_in_a + adder_in_b;
  assign adder_result   = adder_sum[32:1];
  assign adder_result_o = adder_result;

  //////////////////////////////////////////////////////////////////////
  // shifter
  //////////////////////////////////////////////////////////////////////

  logic        shift_left;
  logic        shift_arith;
  logic [4:0]  shift_amt;
  logic [31:0] operand_a_rev;
  logic [31:0] shift_in;
  logic [32:0] shift_right_ext;
  logic [31:0] shift_right_result;
  logic [31:0] shift_left_result;
  logic [31:0] shift_result;

  // only the low five bits of b count
  assign shift_amt   = operand_b_i[4:0];
  assign shift_left  = (operator_i == ALU_SLL);
  assign shift_arith = (operator_i == ALU_SRA);

  // left shift = reverse, shift right, reverse back
  always_comb
  begin
    for (int i = 0; i < 32; i++)
    begin
      operand_a_rev[i] = operand_a_i[31-i];
    end
  end

  assign shift_in = shift_left ? operand_a_rev : operand_a_i;

  // extra top bit carries the fill value, sign for SRA and zero otherwise
  assign shift_right_ext    = $signed({shift_arith & shift_in[31], shift_in}) >>> shift_amt;
  assign shift_right_result = shift_right_ext[31:0];

  always_comb
  begin
    for (int i = 0; i < 32; i++)
    begin
      shift_left_result[i] = shift_right_result[31-i];
    end
  end

  assign shift_result = shift_left ? shift_left_result : shift_right_result;

  //////////////////////////////////////////////////////////////////////
  // comparator
  //////////////////////////////////////////////////////////////////////

  logic cmp_signed;
  logic is_equal;
  logic is_ge;
  logic cmp_result;

  assign cmp_signed = (operator_i == ALU_LTS)  || (operator_i == ALU_LES)  ||
                      (operator_i == ALU_GTS)  || (operator_i == ALU_GES)  ||
                      (operator_i == ALU_SLTS) || (operator_i == ALU_SLETS);

  assign is_equal = (adder_result == 32'h0);

  // same signs: the difference sign decides
  // different signs: a wins unsigned when its msb is set, signed when clear
  always_comb
  begin
    if (operand_a_i[31] == operand_b_i[31])
    begin
      is_ge = ~adder_result[31];
    end
    else
    begin
      is_ge = operand_a_i[31] ^ cmp_signed;
    end
  end

  always_comb
  begin
    cmp_result = 1'b0;
    unique case (operator_i)
      ALU_EQ:             cmp_result = is_equal;
      ALU_NE:             cmp_result = ~is_equal;
      ALU_GTS, ALU_GTU:   cmp_result = is_ge & ~is_equal;
      ALU_GES, ALU_GEU:   cmp_result = is_ge;
      ALU_LTS, ALU_LTU,
      ALU_SLTS, ALU_SLTU: cmp_result = ~is_ge;
      ALU_LES, ALU_LEU,
      ALU_SLETS,
      ALU_SLETU:          cmp_result = ~is_ge | is_equal;
      default: ;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // result mux
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    result_o = 32'h0;
    unique case (operator_i)
      ALU_AND: result_o = operand_a_i & operand_b_i;
      ALU_OR:  result_o = operand_a_i | operand_b_i;
      ALU_XOR: result_o = operand_a_i ^ operand_b_i;

      ALU_ADD, ALU_SUB: result_o = adder_result;

      ALU_SLL, ALU_SRL, ALU_SRA: result_o = shift_result;

      ALU_EQ,    ALU_NE,
      ALU_LTS,   ALU_LTU,
      ALU_LES,   ALU_LEU,
      ALU_GTS,   ALU_GTU,
      ALU_GES,   ALU_GEU,
      ALU_SLTS,  ALU_SLTU,
      ALU_SLETS, ALU_SLETU: result_o = {31'h0, cmp_result};

      // MUL and unused codes give zero here
      default: ;
    endcase
  end

endmodule

/* src/zeroriscy_mult.sv */
`timescale 1ns/1ns

module zeroriscy_mult
  import ex_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,

  input  logic        start_i,
  input  logic [31:0] op_a_i,
  input  logic [31:0] op_b_i,

  // borrowed ALU adder, operands in bits 32:1
  output logic [32:0] mult_operand_a_o,
  output logic [32:0] mult_operand_b_o,
  input  logic [31:0] adder_result_i,

  output logic        busy_o,
  output logic        done_o,
  output logic [31:0] result_o
);

  logic [31:0]           acc_q;
  logic [31:0]           mcand_q;
  logic [31:0]           mplier_q;
  logic [MULT_CNT_W-1:0] step_q;
  logic [31:0]           partial;

  // add the shifted multiplicand when the current multiplier bit is set
  assign partial = mplier_q[0] ? mcand_q : 32'h0;

  assign mult_operand_a_o = {acc_q, 1'b0};
  assign mult_operand_b_o = {partial, 1'b0};

  //////////////////////////////////////////////////////////////////////
  // control, busy for MULT_STEPS cycles then a one-cycle done
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      busy_o <= 1'b0;
      done_o <= 1'b0;
      step_q <= '0;
    end
    else
    begin
      done_o <= 1'b0;
      if (start_i)
      begin
        busy_o <= 1'b1;
        step_q <= '0;
      end
      else if (busy_o)
      begin
        step_q <= step_q + 1'b1;
        // last step, accumulator holds the final sum next cycle
        if (step_q == MULT_CNT_W'(MULT_STEPS - 1))
        begin
          busy_o <= 1'b0;
          done_o <= 1'b1;
        end
      end
    end
  end

  // datapath
  always_ff @(posedge clk_i)
  begin
    if (start_i)
    begin
      acc_q    <= 32'h0;
      mcand_q  <= op_a_i;
      mplier_q <= op_b_i;
    end
    else if (busy_o)
    begin
      acc_q    <= adder_result_i;
      mcand_q  <= {mcand_q[30:0], 1'b0};
      mplier_q <= {1'b0, mplier_q[31:1]};
    end
  end

  assign result_o = acc_q;

endmodule

/* src/zeroriscy_ex_ctrl.sv */
`timescale 1ns/1ns

module zeroriscy_ex_ctrl
  import alu_pkg::*;
  import ex_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_i,

  // operation side
  input  logic                    op_valid_i,
  output logic                    op_ready_o,
  input  logic [ALU_OP_WIDTH-1:0] operator_i,
  input  logic [31:0]             alu_result_i,

  // result side
  output logic                    res_valid_o,
  input  logic                    res_ready_i,
  output logic [31:0]             result_o,

  // multiplier
  output logic                    mult_start_o,
  input  logic                    mult_busy_i,
  input  logic                    mult_done_i,
  input  logic [31:0]             mult_result_i,

  // adder grant to the multiplier
  output logic                    mult_en_o
);

  logic op_is_mul;
  logic op_accept;
  logic alu_accept;
  logic res_consume;

  assign op_is_mul   = (operator_i == EX_OP_MUL);
  assign res_consume = res_valid_o & res_ready_i;

  // no entry while a MUL is running or its result is about to land,
  // a held result may leave on the same edge a new op enters
  assign op_ready_o = ~mult_busy_i & ~mult_done_i & (~res_valid_o | res_ready_i);

  assign op_accept    = op_valid_i & op_ready_o;
  assign alu_accept   = op_accept & ~op_is_mul;
  assign mult_start_o = op_accept & op_is_mul;

  //////////////////////////////////////////////////////////////////////
  // adder ownership
  //////////////////////////////////////////////////////////////////////

  // multiplier owns the adder while busy
  assign mult_en_o = mult_busy_i;

  //////////////////////////////////////////////////////////////////////
  // result register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      res_valid_o <= 1'b0;
    end
    else
    begin
      if (res_consume)
      begin
        res_valid_o <= 1'b0;
      end
      // a fresh result overrides the clear
      if (alu_accept || mult_done_i)
      begin
        res_valid_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (alu_accept)
    begin
      result_o <= alu_result_i;
    end
    else if (mult_done_i)
    begin
      result_o <= mult_result_i;
    end
  end

endmodule

/* src/zeroriscy_ex_top.sv */
`timescale 1ns/1ns

module zeroriscy_ex_top
  import alu_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_i,

  input  logic                    op_valid_i,
  output logic                    op_ready_o,
  input  logic [ALU_OP_WIDTH-1:0] operator_i,
  input  logic [31:0]             operand_a_i,
  input  logic [31:0]             operand_b_i,

  output logic                    res_valid_o,
  input  logic                    res_ready_i,
  output logic [31:0]             result_o
);

  logic [31:0] alu_result;
  logic [31:0] adder_result;
  logic [32:0] mult_operand_a;
  logic [32:0] mult_operand_b;
  logic        mult_en;
  logic        mult_start;
  logic        mult_busy;
  logic        mult_done;
  logic [31:0] mult_result;

  //////////////////////////////////////////////////////////////////////
  // handshake control and result register
  //////////////////////////////////////////////////////////////////////

  zeroriscy_ex_ctrl u_ctrl (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .op_valid_i    (op_valid_i),
    .op_ready_o    (op_ready_o),
    .operator_i    (operator_i),
    .alu_result_i  (alu_result),
    .res_valid_o   (res_valid_o),
    .res_ready_i   (res_ready_i),
    .result_o      (result_o),
    .mult_start_o  (mult_start),
    .mult_busy_i   (mult_busy),
    .mult_done_i   (mult_done),
    .mult_result_i (mult_result),
    .mult_en_o     (mult_en)
  );

  // combinational ALU, adder shared with the multiplier
  zeroriscy_alu u_alu (
    .operator_i       (operator_i),
    .operand_a_i      (operand_a_i),
    .operand_b_i      (operand_b_i),
    .mult_operand_a_i (mult_operand_a),
    .mult_operand_b_i (mult_operand_b),
    .mult_en_i        (mult_en),
    .adder_result_o   (adder_result),
    .result_o         (alu_result)
  );

  // shift-add multiplier, operands sampled on start
  zeroriscy_mult u_mult (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .start_i          (mult_start),
    .op_a_i           (operand_a_i),
    .op_b_i           (operand_b_i),
    .mult_operand_a_o (mult_operand_a),
    .mult_operand_b_o (mult_operand_b),
    .adder_result_i   (adder_result),
    .busy_o           (mult_busy),
    .done_o           (mult_done),
    .result_o         (mult_result)
  );

endmodule

/* verification/zeroriscy_ex_tb.sv */
`timescale 1ns/1ns

module zeroriscy_ex_tb
  import alu_pkg::*;
  import ex_pkg::*;
();

  //////////////////////////////////////////////////////////////////////
  // run sizing
  //////////////////////////////////////////////////////////////////////

  localparam int          CLK_PERIOD   = 10;
  localparam int          RESET_CYCLES = 10;
  localparam logic [31:0] SEED         = 32'h7df61d2e;
  localparam int          N_CORNER     = 5;
  localparam int          N_OPS_ALL    = 23;

  // corner pairs plus random pairs per operator
  localparam int N_ARITH = 5 * (N_CORNER * N_CORNER + 20);
  localparam int N_SHIFT = 3 * 32;
  localparam int N_CMP   = 14 * (N_CORNER * N_CORNER + 10);
  localparam int N_MUL   = N_CORNER * N_CORNER + 20;
  localparam int N_PAIR  = 2 * 10;
  localparam int N_MIX   = 100;
  localparam int NUM_OPS = N_ARITH + N_SHIFT + N_CMP + N_MUL + N_PAIR + N_MIX;

  // worst case per op is a full MUL plus some back-pressure slack
  localparam longint WATCHDOG_NS =
    longint'(RESET_CYCLES + NUM_OPS * (MULT_STEPS + 10)) * CLK_PERIOD;

  logic                    clk_i;
  logic                    rst_i;
  logic                    op_valid_i;
  logic                    op_ready_o;
  logic [ALU_OP_WIDTH-1:0] operator_i;
  logic [31:0]             operand_a_i;
  logic [31:0]             operand_b_i;
  logic                    res_valid_o;
  logic                    res_ready_i;
  logic [31:0]             result_o;

  zeroriscy_ex_top DUT (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .op_valid_i  (op_valid_i),
    .op_ready_o  (op_ready_o),
    .operator_i  (operator_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .res_valid_o (res_valid_o),
    .res_ready_i (res_ready_i),
    .result_o    (result_o)
  );

  logic [31:0]             rnd_state;
  logic [31:0]             bp_state;
  logic [31:0]             corners [N_CORNER];
  logic [ALU_OP_WIDTH-1:0] all_ops [N_OPS_ALL];
  logic [31:0]             exp_q [$];
  logic [31:0]             exp_head;
  int                      exp_count;
  logic                    mul_inflight;
  int                      accepted;
  int                      consumed;
  int                      value_errors;
  int                      protocol_errors;

  logic op_accept;
  logic res_consume;
  logic mul_accept;

  assign op_accept   = op_valid_i & op_ready_o;
  assign res_consume = res_valid_o & res_ready_i;
  assign mul_accept  = op_accept & (operator_i == EX_OP_MUL);

  initial
  begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // random source and reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rnd_state = xorshift32(rnd_state);
    return rnd_state;
  endfunction

  // RV32I semantics where compares give 1 or 0
  function automatic logic [31:0] model_result(input logic [ALU_OP_WIDTH-1:0] op,
                                               input logic [31:0] a,
                                               input logic [31:0] b);
    logic lts;
    logic ltu;
    lts = $signed(a) < $signed(b);
    ltu = a < b;
    case (op)
      ALU_ADD:              return a + b;
      ALU_SUB:              return a - b;
      ALU_XOR:              return a ^ b;
      ALU_OR:               return a | b;
      ALU_AND:              return a & b;
      ALU_SLL:              return a << b[4:0];
      ALU_SRL:              return a >> b[4:0];
      ALU_SRA:              return 32'($signed(a) >>> b[4:0]);
      ALU_LTS, ALU_SLTS:    return {31'h0, lts};
      ALU_LTU, ALU_SLTU:    return {31'h0, ltu};
      ALU_LES, ALU_SLETS:   return {31'h0, lts | (a == b)};
      ALU_LEU, ALU_SLETU:   return {31'h0, ltu | (a == b)};
      ALU_GTS:              return {31'h0, ~lts & (a != b)};
      ALU_GTU:              return {31'h0, ~ltu & (a != b)};
      ALU_GES:              return {31'h0, ~lts};
      ALU_GEU:              return {31'h0, ~ltu};
      ALU_EQ:               return {31'h0, a == b};
      ALU_NE:               return {31'h0, a != b};
      EX_OP_MUL:            return a * b;
      default:              return 32'h0;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // scoreboard of expected results in accept order
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_i)
  begin
    if (!rst_i)
    begin
      // pop before push since an op may enter as the previous result leaves
      if (res_consume)
      begin
        if (exp_q.size() > 0)
        begin
          void'(exp_q.pop_front());
        end
        consumed++;
        mul_inflight = 1'b0;
      end
      if (op_accept)
      begin
        exp_q.push_back(model_result(operator_i, operand_a_i, operand_b_i));
        accepted++;
        if (mul_accept)
        begin
          mul_inflight = 1'b1;
        end
      end
      exp_count = exp_q.size();
      exp_head  = (exp_q.size() > 0) ? exp_q[0] : 32'h0;
    end
  end

  // random back-pressure with ready about three cycles in four
  always @(negedge clk_i)
  begin
    bp_state    = xorshift32(bp_state);
    res_ready_i = (bp_state[1:0] != 2'b00);
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  a_result_value: assert property (@(posedge clk_i) disable iff (rst_i)
    res_consume |-> (result_o == exp_head))
  else
  begin
    value_errors++;
    $display("FAILED at %0t ns: result_o expected %08h, actual %08h",
             $time, $sampled(exp_head), $sampled(result_o));
  end

  a_no_extra_result: assert property (@(posedge clk_i) disable iff (rst_i)
    res_consume |-> (exp_count != 0))
  else
  begin
    protocol_errors++;
    $display("a result was handed out with no operation waiting for it at %0t ns", $time);
  end

  a_hold_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (res_valid_o && !res_ready_i) |=> (res_valid_o && $stable(result_o)))
  else
  begin
    protocol_errors++;
    $display("held result dropped or changed under back-pressure at %0t ns", $time);
  end

  a_hold_blocks_input: assert property (@(posedge clk_i) disable iff (rst_i)
    (res_valid_o && !res_ready_i) |-> !op_ready_o)
  else
  begin
    protocol_errors++;
    $display("op_ready_o high while a result was held at %0t ns", $time);
  end

  a_alu_latency: assert property (@(posedge clk_i) disable iff (rst_i)
    (op_accept && !mul_accept) |=> res_valid_o)
  else
  begin
    protocol_errors++;
    $display("ALU result not valid one cycle after accept at %0t ns", $time);
  end

  // rise on edge 33 is first seen in the sample of edge 34
  a_mul_latency: assert property (@(posedge clk_i) disable iff (rst_i)
    mul_accept |-> ##(MULT_STEPS + 2) $rose(res_valid_o))
  else
  begin
    protocol_errors++;
    $display("MUL result did not arrive exactly 33 cycles after accept at %0t ns", $time);
  end

  a_mul_blocks_input: assert property (@(posedge clk_i) disable iff (rst_i)
    (mul_inflight && !res_consume) |-> !op_ready_o)
  else
  begin
    protocol_errors++;
    $display("new operation allowed in before the MUL result left at %0t ns", $time);
  end

  a_reset_state: assert property (@(posedge clk_i)
    $fell(rst_i) |-> (!res_valid_o && op_ready_o))
  else
  begin
    protocol_errors++;
    $display("wrong handshake state right after reset at %0t ns", $time);
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  // entered and left on a falling edge
  task automatic send_op(input logic [ALU_OP_WIDTH-1:0] op,
                         input logic [31:0] a,
                         input logic [31:0] b);
    op_valid_i  = 1'b1;
    operator_i  = op;
    operand_a_i = a;
    operand_b_i = b;
    do
    begin
      @(posedge clk_i);
    end
    while (!op_ready_o);
    @(negedge clk_i);
    op_valid_i = 1'b0;
  endtask

  task automatic run_op(input logic [ALU_OP_WIDTH-1:0] op, input int n_rand);
    logic [31:0] a;
    logic [31:0] b;
    for (int i = 0; i < N_CORNER; i++)
    begin
      for (int j = 0; j < N_CORNER; j++)
      begin
        send_op(op, corners[i], corners[j]);
      end
    end
    for (int k = 0; k < n_rand; k++)
    begin
      a = next_rand();
      b = next_rand();
      send_op(op, a, b);
    end
  endtask

  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the test sequence finished");
    $display("Verification failed");
    $finish;
  end

  initial
  begin
    logic [31:0] a;
    logic [31:0] b;
    rst_i           = 1'b1;
    op_valid_i      = 1'b0;
    operator_i      = ALU_ADD;
    operand_a_i     = 32'h0;
    operand_b_i     = 32'h0;
    res_ready_i     = 1'b0;
    rnd_state       = SEED;
    bp_state        = SEED ^ 32'h9e3779b9;
    exp_head        = 32'h0;
    exp_count       = 0;
    mul_inflight    = 1'b0;
    accepted        = 0;
    consumed        = 0;
    value_errors    = 0;
    protocol_errors = 0;
    corners = '{32'h0, 32'hffffffff, 32'h80000000, 32'h7fffffff, 32'h1};
    // arith 0..4, shifts 5..7, compares 8..21, MUL last
    all_ops = '{ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
                ALU_SLL, ALU_SRL, ALU_SRA,
                ALU_LTS, ALU_LTU, ALU_LES, ALU_LEU, ALU_GTS, ALU_GTU, ALU_GES,
                ALU_GEU, ALU_EQ, ALU_NE, ALU_SLTS, ALU_SLTU, ALU_SLETS, ALU_SLETU,
                EX_OP_MUL};

    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_i = 1'b0;
    @(negedge clk_i);

    for (int i = 0; i < 5; i++)
    begin
      run_op(all_ops[i], 20);
    end

    // every shift amount with junk in b[31:5] and the sign of a alternating
    for (int i = 5; i < 8; i++)
    begin
      for (int sh = 0; sh < 32; sh++)
      begin
        a = next_rand();
        a[31] = sh[0];
        b = next_rand();
        b[4:0] = sh[4:0];
        send_op(all_ops[i], a, b);
      end
    end

    for (int i = 8; i < 22; i++)
    begin
      run_op(all_ops[i], 10);
    end

    run_op(EX_OP_MUL, 20);

    // ALU op queued right behind a MUL
    for (int k = 0; k < 10; k++)
    begin
      a = next_rand();
      b = next_rand();
      send_op(EX_OP_MUL, a, b);
      a = next_rand();
      b = next_rand();
      send_op(all_ops[k % 8], a, b);
    end

    for (int k = 0; k < N_MIX; k++)
    begin
      a = next_rand();
      b = next_rand();
      send_op(all_ops[next_rand() % N_OPS_ALL], a, b);
    end

    // drain what is still in flight
    while (exp_count != 0)
    begin
      @(negedge clk_i);
    end

    if (accepted != consumed)
    begin
      protocol_errors++;
      $display("operations accepted and results consumed do not match");
    end

    $display("errors: %0d value, %0d protocol; %0d ops accepted, %0d results consumed",
             value_errors, protocol_errors, accepted, consumed);
    if (value_errors == 0 && protocol_errors == 0)
    begin
      $display("Verification passed");
    end
    else
    begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* zeroriscy_ex_top.f */
common/alu_pkg.sv
common/ex_pkg.sv
alu/zeroriscy_alu.sv
src/zeroriscy_mult.sv
src/zeroriscy_ex_ctrl.sv
src/zeroriscy_ex_top.sv
verification/zeroriscy_ex_tb.sv
